//--- all.f
+incdir+verification
verilog/execPkg.sv
verilog/operandSelect.sv
verilog/alu.sv
verilog/resultSelect.sv
verilog/executeStage.sv
verification/tbExecuteStage.sv

//--- Makefile
# Verilator flow for the execute stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f all.f --top-module tbExecuteStage -Mdir obj_dir

# The run passes only if the testbench printed its pass line
run: compile
	@out="$$(./obj_dir/VtbExecuteStage 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

//--- verification/execModel.svh
// Expected values from the ISA rules; include inside the testbench module, relies on execPkg
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Operand source for a forward select
function automatic execPkg::word_t modelForward(
    input execPkg::fwdSel_t sel,
    input execPkg::word_t   regVal,
    input execPkg::word_t   memWbAlu,
    input execPkg::word_t   exMemAlu,
    input execPkg::word_t   memWbMem
);
    case (sel)
        execPkg::FWD_REG:       return regVal;
        execPkg::FWD_MEMWB_ALU: return memWbAlu;
        execPkg::FWD_EXMEM_ALU: return exMemAlu;
        default:                return memWbMem;
    endcase
endfunction

function automatic execPkg::word_t modelOperandA(input execPkg::aluOp_t op,
                                                 input execPkg::word_t fwdA);
    if (op == execPkg::OP_LBI) return '0;
    if (op == execPkg::OP_SLBI) return fwdA << 8;   // Low byte moves to the high byte
    return fwdA;
endfunction

function automatic execPkg::word_t modelOperandB(input execPkg::aluOp_t op,
                                                 input execPkg::word_t fwdB,
                                                 input execPkg::word_t imm,
                                                 input logic useImm);
    if (op[4:2] == execPkg::BRANCH_CLASS[4:2]) return '0;
    return useImm ? imm : fwdB;
endfunction

// Sums are formed as integers so that carry and overflow follow from the range
task automatic modelAlu(
    input  execPkg::word_t    a,
    input  execPkg::word_t    b,
    input  execPkg::aluCtrl_t ctrl,
    input  logic              invA,
    input  logic              invB,
    input  logic              cIn,
    input  logic              sign,
    output execPkg::word_t    res,
    output logic              zero,
    output logic              ltz,
    output logic              ofl
);
    execPkg::word_t x;
    execPkg::word_t y;
    int             n;
    int             sSum;
    int             uSum;
    x    = invA ? ~a : a;
    y    = invB ? ~b : b;
    n    = int'(y[3:0]);
    sSum = int'($signed(x)) + int'($signed(y)) + int'(cIn);
    uSum = int'(x) + int'(y) + int'(cIn);
    ofl  = 1'b0;
    case (ctrl)
        execPkg::ALU_ROL: res = (x << n) | (x >> (16 - n));
        execPkg::ALU_SHL: res = x << n;
        execPkg::ALU_ROR: res = (x >> n) | (x << (16 - n));
        execPkg::ALU_SRL: res = x >> n;
        execPkg::ALU_ADD: begin
            res = execPkg::word_t'(uSum);
            ofl = sign ? ((sSum > 32767) || (sSum < -32768)) : (uSum > 65535);
        end
        execPkg::ALU_AND: res = x & y;
        execPkg::ALU_OR:  res = x | y;
        default:          res = x ^ y;
    endcase
    zero = (res == '0);
    if (ctrl != execPkg::ALU_ADD) ltz = res[15];
    else ltz = sign ? (sSum < 0) : (uSum < 65536);   // Unsigned case is the borrow
endtask

function automatic execPkg::word_t modelResult(
    input execPkg::aluOp_t op,
    input execPkg::word_t  fwdA,
    input execPkg::word_t  pc,
    input execPkg::word_t  aluOut,
    input logic            zero,
    input logic            ltz,
    input logic            ofl
);
    execPkg::word_t rev;
    logic           cond;
    for (int i = 0; i < 16; i++) begin
        rev[15 - i] = fwdA[i];
    end
    case (op[1:0])
        execPkg::SET_EQZ: cond = zero;
        execPkg::SET_LTZ: cond = ltz;
        execPkg::SET_LEZ: cond = zero | ltz;
        default:          cond = ofl;
    endcase
    if ((op == execPkg::OP_JAL) || (op == execPkg::OP_JALR)) return pc;
    if (op == execPkg::OP_BTR) return rev;
    if (op[4:2] == execPkg::SET_CLASS[4:2]) return {15'b0, cond};
    return aluOut;
endfunction

`endif

//--- verification/tbExecuteStage.sv
// Directed tests of the execute stage; stops at the first mismatch and needs timing support
`timescale 1ns/1ps
`default_nettype none

module tbExecuteStage;

    `include "execModel.svh"

    localparam int CLK_PERIOD = 8;
    localparam int NUM_INSTR  = 8 * 5 * 3 + 20 + 10 + 17 + 6 + 1;
    localparam execPkg::aluOp_t OP_PLAIN = 5'b01000;  // No special execute handling

    logic              clk = 1'b0;
    logic              rstN;
    logic              inValid;
    logic              stall;
    logic              aluSrc;
    logic              invA, invB, cIn, sign;
    execPkg::word_t    readData1, readData2, immVal, pc;
    execPkg::word_t    aluResExMem, aluResMemWb, memDataMemWb;
    execPkg::aluCtrl_t aluControl;
    execPkg::aluOp_t   aluOp;
    execPkg::fwdSel_t  forwardA, forwardB;
    logic              outValid, zero, ltz, err;
    execPkg::word_t    aluRes, memWriteData;
    int                seed = 32'ha0bb_bf74;

    executeStage u_executeStage (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Each instruction needs two cycles, so ten periods leave ample margin
    initial begin
        #(CLK_PERIOD * 10 * NUM_INSTR);
        $display("Timeout: tests did not finish within %0d clock periods", 10 * NUM_INSTR);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic execPkg::word_t randWord();
        return execPkg::word_t'($random(seed));
    endfunction

    task automatic checkValue(input string name, input execPkg::word_t exp,
                              input execPkg::word_t act);
        assert (act === exp) else begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("TB FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // Plain register operands, later NBAs in the same step may override any field
    task automatic driveBasic(input execPkg::aluCtrl_t ctrl, input execPkg::word_t a,
                              input execPkg::word_t b, input logic ia, input logic ib,
                              input logic ci, input logic sg);
        @(posedge clk);
        inValid      <= 1'b1;
        stall        <= 1'b0;
        readData1    <= a;
        readData2    <= b;
        immVal       <= randWord();
        aluControl   <= ctrl;
        aluSrc       <= 1'b0;
        invA         <= ia;
        invB         <= ib;
        cIn          <= ci;
        sign         <= sg;
        aluOp        <= OP_PLAIN;
        forwardA     <= execPkg::FWD_REG;
        forwardB     <= execPkg::FWD_REG;
        aluResExMem  <= randWord();
        aluResMemWb  <= randWord();
        memDataMemWb <= randWord();
        pc           <= randWord();
    endtask

    task automatic checkResult();
        execPkg::word_t fA;
        execPkg::word_t fB;
        execPkg::word_t expAlu;
        logic           expZero;
        logic           expLtz;
        logic           expOfl;
        @(posedge clk);   // Capture edge
        @(negedge clk);
        fA = modelForward(forwardA, readData1, aluResMemWb, aluResExMem, memDataMemWb);
        fB = modelForward(forwardB, readData2, aluResMemWb, aluResExMem, memDataMemWb);
        modelAlu(modelOperandA(aluOp, fA), modelOperandB(aluOp, fB, immVal, aluSrc),
                 aluControl, invA, invB, cIn, sign, expAlu, expZero, expLtz, expOfl);
        checkValue("outValid", 16'd1, execPkg::word_t'(outValid));
        checkValue("aluRes", modelResult(aluOp, fA, pc, expAlu, expZero, expLtz, expOfl), aluRes);
        checkValue("memWriteData", fB, memWriteData);
        checkValue("zero", execPkg::word_t'(expZero), execPkg::word_t'(zero));
        checkValue("ltz", execPkg::word_t'(expLtz), execPkg::word_t'(ltz));
        checkValue("err", execPkg::word_t'(expOfl), execPkg::word_t'(err));
    endtask

    task automatic testAluOps();
        // {invA, invB, cIn, sign}: plain, signed, a-b signed, a-b unsigned, b-a signed
        logic [3:0]     modes [5] = '{4'b0000, 4'b0001, 4'b0111, 4'b0110, 4'b1011};
        execPkg::word_t a;
        for (int c = 0; c < 8; c++) begin
            for (int m = 0; m < 5; m++) begin
                for (int r = 0; r < 3; r++) begin
                    a = randWord();
                    driveBasic(execPkg::aluCtrl_t'(c), a, (r == 2) ? a : randWord(),
                               modes[m][3], modes[m][2], modes[m][1], modes[m][0]);
                    checkResult();
                end
            end
        end
    endtask

    task automatic testForwarding();
        for (int s = 0; s < 20; s++) begin
            driveBasic(execPkg::ALU_ADD, 16'h1111, 16'h2222, 1'b0, 1'b0, 1'b0, 1'b0);
            aluResMemWb  <= 16'h4444;
            aluResExMem  <= 16'h8888;
            memDataMemWb <= 16'hf0f0;
            forwardA     <= execPkg::fwdSel_t'(s >> 2);
            forwardB     <= execPkg::fwdSel_t'(s);
            if (s >= 16) aluSrc <= 1'b1;   // Immediate replaces the second operand
            checkResult();
        end
    endtask

    task automatic testSpecialOps();
        execPkg::word_t a;
        execPkg::word_t imm;
        execPkg::word_t rev;
        for (int r = 0; r < 2; r++) begin
            a   = randWord();
            imm = randWord() & 16'h00ff;
            rev = {<<{a}};
            driveBasic(execPkg::ALU_OR, randWord(), randWord(), 1'b0, 1'b0, 1'b0, 1'b0);
            aluOp  <= execPkg::OP_LBI;
            aluSrc <= 1'b1;
            immVal <= imm;
            checkResult();
            checkValue("aluRes (lbi)", imm, aluRes);
            driveBasic(execPkg::ALU_OR, a, randWord(), 1'b0, 1'b0, 1'b0, 1'b0);
            aluOp  <= execPkg::OP_SLBI;
            aluSrc <= 1'b1;
            immVal <= imm;
            checkResult();
            checkValue("aluRes (slbi)", {a[7:0], imm[7:0]}, aluRes);
            driveBasic(execPkg::ALU_OR, randWord(), randWord(), 1'b0, 1'b0, 1'b0, 1'b0);
            aluOp       <= execPkg::OP_BTR;
            forwardA    <= execPkg::FWD_EXMEM_ALU;  // Reverse must see the forwarded value
            aluResExMem <= a;
            checkResult();
            checkValue("aluRes (btr)", rev, aluRes);
            driveBasic(execPkg::ALU_ADD, randWord(), randWord(), 1'b0, 1'b0, 1'b0, 1'b0);
            aluOp <= (r == 0) ? execPkg::OP_JAL : execPkg::OP_JALR;
            pc    <= a;
            checkResult();
            checkValue("aluRes (link)", a, aluRes);
            // Zero operand first, then a negative one
            a = (r == 0) ? '0 : (a | 16'h8000);
            driveBasic(execPkg::ALU_OR, a, randWord(), 1'b0, 1'b0, 1'b0, 1'b0);
            aluOp <= execPkg::BRANCH_CLASS | execPkg::aluOp_t'(r);
            checkResult();
            checkValue("zero (branch)", execPkg::word_t'(a == '0), execPkg::word_t'(zero));
            checkValue("ltz (branch)", execPkg::word_t'(a[15]), execPkg::word_t'(ltz));
        end
    endtask

    task automatic testSetOps();
        // Equal, less, greater, and a signed overflow on a - b
        execPkg::word_t pairA [4] = '{16'h0005, 16'h0003, 16'h0007, 16'h7fff};
        execPkg::word_t pairB [4] = '{16'h0005, 16'h0007, 16'h0003, 16'hffff};
        for (int cond = 0; cond < 4; cond++) begin
            for (int p = 0; p < 4; p++) begin
                driveBasic(execPkg::ALU_ADD, pairA[p], pairB[p], 1'b0, 1'b1, 1'b1, 1'b1);
                aluOp <= execPkg::SET_CLASS | execPkg::aluOp_t'(cond);
                checkResult();
            end
        end
        driveBasic(execPkg::ALU_ADD, 16'h7fff, 16'h0001, 1'b0, 1'b0, 1'b0, 1'b1);
        checkResult();
        checkValue("err (signed add)", 16'd1, execPkg::word_t'(err));
    endtask

    task automatic testStall();
        execPkg::word_t heldRes;
        execPkg::word_t heldData;
        logic [3:0]     heldBits;
        driveBasic(execPkg::ALU_ADD, randWord(), randWord(), 1'b0, 1'b0, 1'b0, 1'b1);
        checkResult();
        heldRes  = aluRes;
        heldData = memWriteData;
        heldBits = {outValid, zero, ltz, err};
        // First pass raises stall, three more are fully stalled
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            stall       <= 1'b1;
            inValid     <= i[0];
            readData1   <= randWord();
            readData2   <= randWord();
            aluControl  <= execPkg::aluCtrl_t'(randWord());
            aluOp       <= execPkg::aluOp_t'(randWord());
            forwardA    <= execPkg::fwdSel_t'(randWord());
            aluResExMem <= randWord();
            @(negedge clk);
            checkValue("aluRes (stalled)", heldRes, aluRes);
            checkValue("memWriteData (stalled)", heldData, memWriteData);
            checkValue("outValid/zero/ltz/err (stalled)", execPkg::word_t'(heldBits),
                       execPkg::word_t'({outValid, zero, ltz, err}));
        end
        driveBasic(execPkg::ALU_XOR, randWord(), randWord(), 1'b0, 1'b0, 1'b0, 1'b0);
        checkResult();
    endtask

    task automatic testIdle();
        @(posedge clk);
        inValid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        checkValue("outValid (idle)", 16'd0, execPkg::word_t'(outValid));
    endtask

    initial begin
        rstN         = 1'b0;
        inValid      = 1'b1;   // Reset has to win over a valid instruction
        stall        = 1'b0;
        aluSrc       = 1'b0;
        invA         = 1'b0;
        invB         = 1'b0;
        cIn          = 1'b0;
        sign         = 1'b0;
        readData1    = '0;
        readData2    = '0;
        immVal       = '0;
        pc           = '0;
        aluResExMem  = '0;
        aluResMemWb  = '0;
        memDataMemWb = '0;
        aluControl   = execPkg::ALU_ADD;
        aluOp        = OP_PLAIN;
        forwardA     = execPkg::FWD_REG;
        forwardB     = execPkg::FWD_REG;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("outValid (reset)", 16'd0, execPkg::word_t'(outValid));
        testAluOps();
        testForwarding();
        testSpecialOps();
        testSetOps();
        testStall();
        testIdle();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
// Execute stage only; forwarding selects and stall must come from external hazard logic
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  logic              stall,
    input  execPkg::word_t    readData1,   // Rs
    input  execPkg::word_t    readData2,   // Rt or Rd
    input  execPkg::word_t    immVal,
    input  execPkg::aluCtrl_t aluControl,
    input  logic              aluSrc,
    input  logic              invA,
    input  logic              invB,
    input  logic              cIn,
    input  logic              sign,
    input  execPkg::aluOp_t   aluOp,
    input  execPkg::fwdSel_t  forwardA,
    input  execPkg::fwdSel_t  forwardB,
    input  execPkg::word_t    aluResExMem,
    input  execPkg::word_t    aluResMemWb,
    input  execPkg::word_t    memDataMemWb,
    input  execPkg::word_t    pc,
    output logic              outValid,
    output execPkg::word_t    aluRes,
    output execPkg::word_t    memWriteData,
    output logic              zero,
    output logic              ltz,
    output logic              err
);

    execPkg::word_t fwdA;
    execPkg::word_t aluInA;
    execPkg::word_t aluInB;
    execPkg::word_t storeData;     // Forwarded second operand
    execPkg::word_t aluOut;
    logic           aluZero;
    logic           aluLtz;
    logic           aluOfl;

    operandSelect u_operandSelect (
        .readData1   (readData1),
        .readData2   (readData2),
        .immVal      (immVal),
        .aluResExMem (aluResExMem),
        .aluResMemWb (aluResMemWb),
        .memDataMemWb(memDataMemWb),
        .forwardA    (forwardA),
        .forwardB    (forwardB),
        .aluSrc      (aluSrc),
        .aluOp       (aluOp),
        .fwdA        (fwdA),
        .aluInA      (aluInA),
        .aluInB      (aluInB),
        .memWriteData(storeData)
    );

    alu u_alu (
        .inA    (aluInA),
        .inB    (aluInB),
        .aluCtrl(aluControl),
        .invA   (invA),
        .invB   (invB),
        .cIn    (cIn),
        .sign   (sign),
        .result (aluOut),
        .zero   (aluZero),
        .ltz    (aluLtz),
        .ofl    (aluOfl)
    );

    resultSelect u_resultSelect (
        .clk           (clk),
        .rstN          (rstN),
        .inValid       (inValid),
        .stall         (stall),
        .aluOut        (aluOut),
        .fwdA          (fwdA),
        .memWriteDataIn(storeData),
        .pc            (pc),
        .aluOp         (aluOp),
        .zeroIn        (aluZero),
        .ltzIn         (aluLtz),
        .oflIn         (aluOfl),
        .outValid      (outValid),
        .aluRes        (aluRes),
        .memWriteData  (memWriteData),
        .zero          (zero),
        .ltz           (ltz),
        .err           (err)
    );

endmodule

`default_nettype wire

//--- verilog/resultSelect.sv
// EX/MEM register; data registers are not reset and only carry meaning while outValid is high
`timescale 1ns/1ps
`default_nettype none

module resultSelect (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  logic            stall,
    input  execPkg::word_t  aluOut,
    input  execPkg::word_t  fwdA,
    input  execPkg::word_t  memWriteDataIn,
    input  execPkg::word_t  pc,
    input  execPkg::aluOp_t aluOp,
    input  logic            zeroIn,
    input  logic            ltzIn,
    input  logic            oflIn,
    output logic            outValid,
    output execPkg::word_t  aluRes,
    output execPkg::word_t  memWriteData,
    output logic            zero,
    output logic            ltz,
    output logic            err
);

    execPkg::word_t revA;
    execPkg::word_t nextRes;
    logic           isLink;
    logic           isBtr;
    logic           isSet;
    logic           setVal;

    assign isLink = (aluOp == execPkg::OP_JAL) || (aluOp == execPkg::OP_JALR);
    assign isBtr  = (aluOp == execPkg::OP_BTR);
    assign isSet  = (aluOp[4:2] == execPkg::SET_CLASS[4:2]);

    // Bit reverse of the forwarded first operand
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            revA[i] = fwdA[15 - i];
        end
    end

    always_comb begin
        case (execPkg::setCond_t'(aluOp[1:0]))
            execPkg::SET_EQZ: setVal = zeroIn;
            execPkg::SET_LTZ: setVal = ltzIn;
            execPkg::SET_LEZ: setVal = zeroIn | ltzIn;
            default:          setVal = oflIn;  // SET_OFL
        endcase
    end

    always_comb begin
        if (isLink) begin
            nextRes = pc;                      // Link address from decode
        end else if (isBtr) begin
            nextRes = revA;
        end else if (isSet) begin
            nextRes = {15'b0, setVal};
        end else begin
            nextRes = aluOut;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (!stall) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            aluRes       <= nextRes;
            memWriteData <= memWriteDataIn;
            zero         <= zeroIn;
            ltz          <= ltzIn;
            err          <= oflIn;             // Overflow is the only error source
        end
    end

    assert property (@(posedge clk) !rstN |=> !outValid)
        else $error("resultSelect: outValid high after reset");

    assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable({outValid, aluRes, memWriteData, zero, ltz, err}))
        else $error("resultSelect: EX/MEM register changed during stall");

endmodule

`default_nettype wire

//--- verilog/alu.sv
// Combinational; shift and rotate amounts use only the low four bits of the second operand
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  execPkg::word_t    inA,
    input  execPkg::word_t    inB,
    input  execPkg::aluCtrl_t aluCtrl,
    input  logic              invA,
    input  logic              invB,
    input  logic              cIn,
    input  logic              sign,
    output execPkg::word_t    result,
    output logic              zero,
    output logic              ltz,
    output logic              ofl
);

    execPkg::word_t opA;
    execPkg::word_t opB;
    logic [3:0]     shAmt;
    logic [31:0]    rolWide;
    logic [31:0]    rorWide;
    logic [16:0]    sumWide;
    logic           carryOut;
    logic           signedOvf;
    logic           isAdd;

    // Inversion comes first, so sub is invA or invB plus cIn
    assign opA = invA ? ~inA : inA;
    assign opB = invB ? ~inB : inB;

    assign shAmt = opB[3:0];

    // Rotates shift a doubled copy and keep one half
    assign rolWide = {opA, opA} << shAmt;
    assign rorWide = {opA, opA} >> shAmt;

    assign sumWide  = {1'b0, opA} + {1'b0, opB} + {16'b0, cIn};
    assign carryOut = sumWide[16];

    // Same-sign operands with a sum of the other sign
    assign signedOvf = (opA[15] == opB[15]) && (sumWide[15] != opA[15]);

    assign isAdd = (aluCtrl == execPkg::ALU_ADD);

    always_comb begin
        result = '0;
        ofl    = 1'b0;
        case (aluCtrl)
            execPkg::ALU_ROL: begin
                result = rolWide[31:16];
            end
            execPkg::ALU_SHL: begin
                result = opA << shAmt;
            end
            execPkg::ALU_ROR: begin
                result = rorWide[15:0];
            end
            execPkg::ALU_SRL: begin
                result = opA >> shAmt;  // Zero fill
            end
            execPkg::ALU_ADD: begin
                result = sumWide[15:0];
                ofl    = sign ? signedOvf : carryOut;
            end
            execPkg::ALU_AND: begin
                result = opA & opB;
            end
            execPkg::ALU_OR: begin
                result = opA | opB;
            end
            default: begin
                result = opA ^ opB;     // ALU_XOR
            end
        endcase
    end

    assign zero = (result == '0);

    // Less than zero as seen by set and branch instructions
    always_comb begin
        if (!isAdd) begin
            ltz = result[15];
        end else if (sign) begin
            ltz = sumWide[15] ^ signedOvf;  // True sign despite overflow
        end else begin
            ltz = ~carryOut;                // Borrow
        end
    end

endmodule

`default_nettype wire

//--- verilog/operandSelect.sv
// Purely combinational; forward selects come straight from hazard logic and are not checked
`timescale 1ns/1ps
`default_nettype none

module operandSelect (
    input  execPkg::word_t  readData1,
    input  execPkg::word_t  readData2,
    input  execPkg::word_t  immVal,
    input  execPkg::word_t  aluResExMem,
    input  execPkg::word_t  aluResMemWb,
    input  execPkg::word_t  memDataMemWb,
    input  execPkg::fwdSel_t forwardA,
    input  execPkg::fwdSel_t forwardB,
    input  logic            aluSrc,
    input  execPkg::aluOp_t aluOp,
    output execPkg::word_t  fwdA,
    output execPkg::word_t  aluInA,
    output execPkg::word_t  aluInB,
    output execPkg::word_t  memWriteData
);

    execPkg::word_t fwdB;
    execPkg::word_t srcB;
    logic           isSlbi;
    logic           isLbi;
    logic           isBranch;

    // One forwarding mux, used for both operands
    function automatic execPkg::word_t pickSource(
        input execPkg::fwdSel_t sel,
        input execPkg::word_t   regVal,
        input execPkg::word_t   exMemAlu,
        input execPkg::word_t   memWbAlu,
        input execPkg::word_t   memWbMem
    );
        case (sel)
            execPkg::FWD_MEMWB_ALU: pickSource = memWbAlu;
            execPkg::FWD_EXMEM_ALU: pickSource = exMemAlu;
            execPkg::FWD_MEMWB_MEM: pickSource = memWbMem;
            default:                pickSource = regVal;
        endcase
    endfunction

    assign fwdA = pickSource(forwardA, readData1, aluResExMem, aluResMemWb, memDataMemWb);
    assign fwdB = pickSource(forwardB, readData2, aluResExMem, aluResMemWb, memDataMemWb);

    assign isSlbi   = (aluOp == execPkg::OP_SLBI);
    assign isLbi    = (aluOp == execPkg::OP_LBI);
    assign isBranch = (aluOp[4:2] == execPkg::BRANCH_CLASS[4:2]);

    // First operand; lbi and slbi are both built as an or with the immediate
    always_comb begin
        if (isLbi) begin
            aluInA = '0;
        end else if (isSlbi) begin
            aluInA = fwdA << execPkg::SLBI_SHIFT; // Old low byte moves up
        end else begin
            aluInA = fwdA;
        end
    end

    assign srcB = aluSrc ? immVal : fwdB;

    // Branches compare the first operand against zero
    assign aluInB = isBranch ? '0 : srcB;

    // Stores take the register operand, never the immediate
    assign memWriteData = fwdB;

endmodule

`default_nettype wire

//--- verilog/execPkg.sv
// Encodings are fixed by the 16-bit ISA; class checks only look at the upper three opcode bits
`default_nettype none

package execPkg;

    typedef logic [15:0] word_t;    // Operands, results, PC, store data
    typedef logic [4:0]  aluOp_t;   // Opcode class field from decode
    typedef logic [2:0]  aluCtrl_t; // ALU operation select
    typedef logic [1:0]  fwdSel_t;  // Operand forwarding select
    typedef logic [1:0]  setCond_t; // Low opcode bits of a set instruction

    // ALU operations
    localparam aluCtrl_t ALU_ROL = 3'd0;
    localparam aluCtrl_t ALU_SHL = 3'd1;
    localparam aluCtrl_t ALU_ROR = 3'd2;
    localparam aluCtrl_t ALU_SRL = 3'd3;
    localparam aluCtrl_t ALU_ADD = 3'd4;
    localparam aluCtrl_t ALU_AND = 3'd5;
    localparam aluCtrl_t ALU_OR  = 3'd6;
    localparam aluCtrl_t ALU_XOR = 3'd7;

    // Forwarding sources
    localparam fwdSel_t FWD_REG       = 2'd0; // Register file
    localparam fwdSel_t FWD_MEMWB_ALU = 2'd1;
    localparam fwdSel_t FWD_EXMEM_ALU = 2'd2;
    localparam fwdSel_t FWD_MEMWB_MEM = 2'd3; // Load data in writeback

    // Opcodes with special execute handling
    localparam aluOp_t OP_SLBI = 5'b10010;
    localparam aluOp_t OP_LBI  = 5'b11000;
    localparam aluOp_t OP_BTR  = 5'b11001;
    localparam aluOp_t OP_JAL  = 5'b00110;
    localparam aluOp_t OP_JALR = 5'b00111;

    // Opcode classes, only bits [4:2] are meaningful
    localparam aluOp_t BRANCH_CLASS = 5'b01100;
    localparam aluOp_t SET_CLASS    = 5'b11100;

    // Set conditions
    localparam setCond_t SET_EQZ = 2'b00;
    localparam setCond_t SET_LTZ = 2'b01;
    localparam setCond_t SET_LEZ = 2'b10; // Zero or less than zero
    localparam setCond_t SET_OFL = 2'b11; // Carry or signed overflow

    // Half-word move of shift-and-load
    localparam int SLBI_SHIFT = 8;

endpackage

`default_nettype wire
